// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = rv_core_tb
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: sim clean

# output is echoed, the exit status comes from the pass message search
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | awk '{print} index($$0, "*** TEST PASSED ***") {ok = 1} END {exit !ok}'

clean:
	rm -rf $(OBJDIR)

// File: compile.f
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/reg_file.sv
source/instr_decode.sv
source/alu_execute.sv
source/mem_writeback.sv
source/rv_core.sv
sim/rv_core_tb.sv

// File: sim/rv_core_tb.sv
//--------------------------------------------------------------------------
// testbench for rv_core with an xorshift instruction stream, an
// architectural reference model and in-order writeback checks
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_core_tb;

	localparam logic [6:0] opc_reg   = 7'b0110011;
	localparam logic [6:0] opc_imm   = 7'b0010011;
	localparam logic [6:0] opc_lui   = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_load  = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;

	// worst case of 8 cycles for each issued instruction
	localparam int total_instr = 241;
	localparam int watchdog_ns = total_instr * 8 * 20 + 4000;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] in_instr;
	logic [31:0] in_pc;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	logic [31:0] rng_state;
	logic [31:0] pc_next;
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [64];
	logic [36:0] exp_q [$];
	int          err_count;
	int          pass_count;
	int          fail_count;
	int          stall_count;

	rv_core rv_core_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// x0..x7 only so dependencies show up often
	function automatic logic [4:0] pick_reg(input logic [31:0] r);
		return {2'b00, r[2:0]};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opc_reg};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// opcodes outside the supported subset
	function automatic logic [6:0] unknown_opc(input logic [2:0] sel);
		case (sel)
			3'd0:    return 7'b1101111;
			3'd1:    return 7'b1100111;
			3'd2:    return 7'b1100011;
			3'd3:    return 7'b0001111;
			default: return 7'b1110011;
		endcase
	endfunction

	// rv32i integer semantics
	// alt selects sub or sra
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end else begin
					return a >> b[4:0];
				end
			end
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	// architectural step in program order that queues the expected writeback
	task automatic model_exec(input logic [31:0] instr, input logic [31:0] pc_v);
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] addr;
		logic [31:0] val;
		logic        wr;
		f3    = instr[14:12];
		rd    = instr[11:7];
		a     = model_regs[instr[19:15]];
		b     = model_regs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		wr    = 1'b0;
		val   = 32'd0;
		case (instr[6:0])
			opc_reg: begin
				val = alu_model(f3, (f3 == 3'd0 || f3 == 3'd5) && instr[30], a, b);
				wr  = 1'b1;
			end
			opc_imm: begin
				val = alu_model(f3, (f3 == 3'd5) && instr[30], a, imm_i);
				wr  = 1'b1;
			end
			opc_lui: begin
				val = {instr[31:12], 12'b0};
				wr  = 1'b1;
			end
			opc_auipc: begin
				val = pc_v + {instr[31:12], 12'b0};
				wr  = 1'b1;
			end
			opc_load: begin
				if (f3 == 3'b010) begin
					addr = a + imm_i;
					val  = model_mem[addr[7:2]];
					wr   = 1'b1;
				end
			end
			opc_store: begin
				if (f3 == 3'b010) begin
					addr = a + imm_s;
					model_mem[addr[7:2]] = b;
				end
			end
			default: begin
			end
		endcase
		if (wr && rd != 5'd0) begin
			model_regs[rd] = val;
			exp_q.push_back({rd, val});
		end
	endtask

	// called 1 ns after a rising edge and returns 1 ns after the accepting edge
	task automatic issue(input logic [31:0] instr);
		logic done;
		done     = 1'b0;
		in_valid = 1'b1;
		in_instr = instr;
		in_pc    = pc_next;
		while (!done) begin
			@(negedge clk);
			if (in_ready) begin
				model_exec(instr, pc_next);
				done = 1'b1;
			end else begin
				stall_count++;
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		pc_next  = pc_next + 32'd4;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 12) begin
			@(posedge clk);
			n++;
		end
		// a few more cycles to catch stray pulses
		repeat (4) @(posedge clk);
		#1;
		if (exp_q.size() != 0) begin
			$display("missing writeback: %0d expected results never appeared", exp_q.size());
			err_count++;
			exp_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			pass_count++;
			$display("test %s: pass", name);
		end else begin
			fail_count++;
			$display("test %s: fail with %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic seed_regs();
		logic [31:0] r;
		for (int i = 1; i < 8; i++) begin
			r = next_rand();
			issue(enc_u(r[31:12], 5'(i), opc_lui));
			issue(enc_i(r[11:0], 5'(i), 3'd0, 5'(i), opc_imm));
		end
	endtask

	task automatic reg_alu_ops();
		int          errs;
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		errs = err_count;
		seed_regs();
		for (int i = 0; i < 40; i++) begin
			r  = next_rand();
			f3 = r[18:16];
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[19]) ? 7'b0100000 : 7'b0000000;
			issue(enc_r(f7, pick_reg(r >> 3), pick_reg(r >> 6), f3, pick_reg(r)));
		end
		drain();
		report_test("r-type ops", errs);
	endtask

	task automatic imm_alu_ops();
		int          errs;
		logic [31:0] r;
		logic [2:0]  f3;
		logic [11:0] imm;
		errs = err_count;
		for (int i = 0; i < 40; i++) begin
			r  = next_rand();
			f3 = r[18:16];
			imm = r[31:20];
			// legal shift encodings only
			if (f3 == 3'd1) begin
				imm = {7'b0, r[24:20]};
			end else if (f3 == 3'd5) begin
				imm = {1'b0, r[25], 5'b0, r[24:20]};
			end
			issue(enc_i(imm, pick_reg(r >> 3), f3, pick_reg(r), opc_imm));
		end
		drain();
		report_test("i-type ops", errs);
	endtask

	task automatic upper_imm_ops();
		int          errs;
		logic [31:0] r;
		errs    = err_count;
		r       = next_rand();
		pc_next = {r[31:2], 2'b00};
		for (int i = 0; i < 20; i++) begin
			r = next_rand();
			issue(enc_u(r[31:12], pick_reg(r), r[3] ? opc_auipc : opc_lui));
		end
		drain();
		report_test("lui and auipc", errs);
	endtask

	task automatic mem_round_trip();
		int          errs;
		logic [31:0] r;
		logic [4:0]  src;
		logic [11:0] offs;
		errs = err_count;
		for (int i = 0; i < 16; i++) begin
			r    = next_rand();
			src  = {2'b00, r[2:0] | 3'd1};
			offs = {4'b0, r[13:8], 2'b00};
			issue(enc_i(r[31:20], src, 3'd0, src, opc_imm));
			issue(enc_s(offs, src, 5'd0));
			issue(enc_i(offs, 5'd0, 3'b010, pick_reg(r >> 4), opc_load));
			r = next_rand();
			issue(enc_i({4'b0, r[13:8], 2'b00}, 5'd0, 3'b010, pick_reg(r), opc_load));
		end
		drain();
		report_test("store and load", errs);
	endtask

	task automatic dep_chains();
		int          errs;
		int          stalls;
		logic [31:0] r;
		logic [4:0]  prev;
		logic [4:0]  rd;
		errs   = err_count;
		stalls = stall_count;
		for (int c = 0; c < 10; c++) begin
			r    = next_rand();
			prev = 5'd1;
			issue(enc_i(r[31:20], 5'd0, 3'd0, prev, opc_imm));
			for (int k = 0; k < 4; k++) begin
				r  = next_rand();
				rd = {2'b00, r[2:0] | 3'd1};
				if (r[3]) begin
					issue(enc_r(r[4] ? 7'b0100000 : 7'b0, prev, prev, 3'd0, rd));
				end else begin
					issue(enc_i(r[31:20], prev, 3'd4, rd, opc_imm));
				end
				prev = rd;
			end
		end
		drain();
		if (stall_count == stalls) begin
			$display("dependency chains never held in_ready low");
			err_count++;
		end
		report_test("dependency chains", errs);
	endtask

	task automatic x0_and_unknown();
		int          errs;
		logic [31:0] r;
		errs = err_count;
		r    = next_rand();
		issue(enc_i(r[31:20], 5'd0, 3'd0, 5'd0, opc_imm));
		issue(enc_r(7'b0, 5'd2, 5'd1, 3'd0, 5'd0));
		issue(enc_u(r[19:0], 5'd0, opc_lui));
		issue(enc_i(12'h010, 5'd0, 3'b010, 5'd0, opc_load));
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			issue({r[31:7], unknown_opc(r[2:0])});
		end
		// x0 must still read as zero
		issue(enc_i(12'h123, 5'd0, 3'd0, 5'd3, opc_imm));
		issue(enc_r(7'b0, 5'd0, 5'd0, 3'd0, 5'd4));
		issue(enc_r(7'b0100000, 5'd1, 5'd0, 3'd0, 5'd5));
		issue(enc_i(12'hfff, 5'd0, 3'd4, 5'd6, opc_imm));
		drain();
		report_test("x0 and unknown opcodes", errs);
	endtask

	// writeback monitor sampled mid-cycle
	initial begin
		logic [36:0] head;
		forever begin
			@(negedge clk);
			if (!rst && wb_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("unexpected writeback pulse to x%0d with data %h", wb_rd, wb_data);
					err_count++;
				end else begin
					head = exp_q.pop_front();
					if (wb_rd !== head[36:32]) begin
						$display("ERROR wb_rd expected %h got %h", head[36:32], wb_rd);
						err_count++;
					end
					if (wb_data !== head[31:0]) begin
						$display("ERROR wb_data expected %h got %h", head[31:0], wb_data);
						err_count++;
					end
				end
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: run did not finish within %0d ns", watchdog_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int stalls;
		rst         = 1'b1;
		in_valid    = 1'b0;
		in_instr    = 32'd0;
		in_pc       = 32'd0;
		rng_state   = 32'd99;
		pc_next     = 32'h0000_1000;
		err_count   = 0;
		pass_count  = 0;
		fail_count  = 0;
		stall_count = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = 32'd0;
		end
		for (int i = 0; i < 64; i++) begin
			model_mem[i] = 32'd0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		if (wb_valid !== 1'b0) begin
			$display("wb_valid is not low after reset");
			err_count++;
		end
		// reads x1 and x2 while nothing can be in flight yet
		stalls = stall_count;
		issue(enc_r(7'b0, 5'd2, 5'd1, 3'd0, 5'd0));
		if (stall_count != stalls) begin
			$display("in_ready was low for the first instruction after reset");
			err_count++;
		end
		reg_alu_ops();
		imm_alu_ops();
		upper_imm_ops();
		mem_round_trip();
		dep_chains();
		x0_and_unknown();
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: source/alu_execute.sv
//--------------------------------------------------------------------------
// execute stage: operand selection, alu and the execute-to-result register
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module alu_execute (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ex_valid,
	input  rv_pipe_pkg::alu_op_t              ex_alu_op,
	input  rv_pipe_pkg::src_a_t               ex_src_a,
	input  logic                              ex_use_imm,
	input  logic [rv_isa_pkg::xlen-1:0]       ex_a,
	input  logic [rv_isa_pkg::xlen-1:0]       ex_b,
	input  logic [rv_isa_pkg::xlen-1:0]       ex_imm,
	input  logic [rv_isa_pkg::xlen-1:0]       ex_pc,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] ex_rd,
	input  logic                              ex_reg_write,
	input  logic                              ex_mem_read,
	input  logic                              ex_mem_write,
	output logic                              mw_valid,
	output logic [rv_isa_pkg::xlen-1:0]       mw_result,
	output logic [rv_isa_pkg::xlen-1:0]       mw_store_data,
	output logic [rv_isa_pkg::reg_addr_w-1:0] mw_rd,
	output logic                              mw_reg_write,
	output logic                              mw_mem_read,
	output logic                              mw_mem_write
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;
	logic [xlen-1:0] alu_out;

	always_comb begin
		case (ex_src_a)
			src_rs1: op_a = ex_a;
			src_pc:  op_a = ex_pc;
			default: op_a = '0;
		endcase
	end

	assign op_b  = ex_use_imm ? ex_imm : ex_b;
	assign shamt = op_b[4:0];

	// lw/sw addresses come through alu_add as well
	always_comb begin
		case (ex_alu_op)
			alu_add:  alu_out = op_a + op_b;
			alu_sub:  alu_out = op_a - op_b;
			alu_sll:  alu_out = op_a << shamt;
			alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_xor:  alu_out = op_a ^ op_b;
			alu_srl:  alu_out = op_a >> shamt;
			alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
			alu_or:   alu_out = op_a | op_b;
			alu_and:  alu_out = op_a & op_b;
			default:  alu_out = op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mw_valid     <= 1'b0;
			mw_reg_write <= 1'b0;
			mw_mem_read  <= 1'b0;
			mw_mem_write <= 1'b0;
		end else begin
			mw_valid     <= ex_valid;
			mw_reg_write <= ex_valid && ex_reg_write;
			mw_mem_read  <= ex_valid && ex_mem_read;
			mw_mem_write <= ex_valid && ex_mem_write;
		end
	end

	// store data is rs2, never the immediate
	always_ff @(posedge clk) begin
		mw_result     <= alu_out;
		mw_store_data <= ex_b;
		mw_rd         <= ex_rd;
	end

endmodule

// File: source/instr_decode.sv
//--------------------------------------------------------------------------
// decode stage with field extraction, immediates, alu op selection, the
// stall against in-flight writers and the decode-to-execute register
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module instr_decode (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              in_valid,
	output logic                              in_ready,
	input  logic [rv_isa_pkg::xlen-1:0]       in_instr,
	input  logic [rv_isa_pkg::xlen-1:0]       in_pc,
	output logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr,
	output logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic [rv_isa_pkg::xlen-1:0]       rs1_data,
	input  logic [rv_isa_pkg::xlen-1:0]       rs2_data,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] mw_rd,
	input  logic                              mw_reg_write,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                              wb_valid,
	output logic                              ex_valid,
	output rv_pipe_pkg::alu_op_t              ex_alu_op,
	output rv_pipe_pkg::src_a_t               ex_src_a,
	output logic                              ex_use_imm,
	output logic [rv_isa_pkg::xlen-1:0]       ex_a,
	output logic [rv_isa_pkg::xlen-1:0]       ex_b,
	output logic [rv_isa_pkg::xlen-1:0]       ex_imm,
	output logic [rv_isa_pkg::xlen-1:0]       ex_pc,
	output logic [rv_isa_pkg::reg_addr_w-1:0] ex_rd,
	output logic                              ex_reg_write,
	output logic                              ex_mem_read,
	output logic                              ex_mem_write
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	opcode_t               opcode;
	logic [2:0]            funct3;
	logic                  funct7_b30;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm_u;
	logic                  reads_rs1;
	logic                  reads_rs2;
	logic                  hazard;
	logic                  accept;
	alu_op_t               dec_alu_op;
	src_a_t                dec_src_a;
	logic                  dec_use_imm;
	logic [xlen-1:0]       dec_imm;
	logic                  dec_reg_write;
	logic                  dec_mem_read;
	logic                  dec_mem_write;

	// is r the destination of a writer still in ex, mw or wb
	function automatic logic in_flight(input logic [reg_addr_w-1:0] r);
		in_flight = (r != '0) &&
			((ex_reg_write && (ex_rd == r)) ||
			 (mw_reg_write && (mw_rd == r)) ||
			 (wb_valid && (wb_rd == r)));
	endfunction

	// funct3 plus bit 30 to alu op; only register ops have sub
	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic b30,
		input logic is_reg);
		case (f3)
			f3_add:  alu_sel = (is_reg && b30) ? alu_sub : alu_add;
			f3_sll:  alu_sel = alu_sll;
			f3_slt:  alu_sel = alu_slt;
			f3_sltu: alu_sel = alu_sltu;
			f3_xor:  alu_sel = alu_xor;
			f3_sr:   alu_sel = b30 ? alu_sra : alu_srl;
			f3_or:   alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	endfunction

	assign opcode     = opcode_t'(in_instr[6:0]);
	assign rd         = in_instr[11:7];
	assign funct3     = in_instr[14:12];
	assign rs1_addr   = in_instr[19:15];
	assign rs2_addr   = in_instr[24:20];
	assign funct7_b30 = in_instr[30];

	// sign extended immediates
	assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
	assign imm_s = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
	assign imm_u = {in_instr[31:12], 12'b0};

	always_comb begin
		dec_alu_op    = alu_pass_b;
		dec_src_a     = src_zero;
		dec_use_imm   = 1'b0;
		dec_imm       = '0;
		dec_reg_write = 1'b0;
		dec_mem_read  = 1'b0;
		dec_mem_write = 1'b0;
		reads_rs1     = 1'b0;
		reads_rs2     = 1'b0;
		case (opcode)
			op_reg: begin
				dec_alu_op    = alu_sel(funct3, funct7_b30, 1'b1);
				dec_src_a     = src_rs1;
				dec_reg_write = 1'b1;
				reads_rs1     = 1'b1;
				reads_rs2     = 1'b1;
			end
			op_imm: begin
				dec_alu_op    = alu_sel(funct3, funct7_b30, 1'b0);
				dec_src_a     = src_rs1;
				dec_use_imm   = 1'b1;
				dec_imm       = imm_i;
				dec_reg_write = 1'b1;
				reads_rs1     = 1'b1;
			end
			op_lui, op_auipc: begin
				dec_alu_op    = alu_add;
				dec_src_a     = (opcode == op_auipc) ? src_pc : src_zero;
				dec_use_imm   = 1'b1;
				dec_imm       = imm_u;
				dec_reg_write = 1'b1;
			end
			op_load: begin
				// only lw here
				// other widths fall through as no-ops
				if (funct3 == f3_word) begin
					dec_alu_op    = alu_add;
					dec_src_a     = src_rs1;
					dec_use_imm   = 1'b1;
					dec_imm       = imm_i;
					dec_reg_write = 1'b1;
					dec_mem_read  = 1'b1;
					reads_rs1     = 1'b1;
				end
			end
			op_store: begin
				if (funct3 == f3_word) begin
					dec_alu_op    = alu_add;
					dec_src_a     = src_rs1;
					dec_use_imm   = 1'b1;
					dec_imm       = imm_s;
					dec_mem_write = 1'b1;
					reads_rs1     = 1'b1;
					reads_rs2     = 1'b1;
				end
			end
			default: begin
				// unknown opcode retires with no effect
			end
		endcase
	end

	// hold the instruction while a source is still being produced
	always_comb begin
		hazard = (reads_rs1 && in_flight(rs1_addr)) || (reads_rs2 && in_flight(rs2_addr));
	end

	assign in_ready = !(in_valid && hazard);
	assign accept   = in_valid && in_ready;

	// control bits carry a bubble when nothing is accepted
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid     <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
		end else begin
			ex_valid     <= accept;
			ex_reg_write <= accept && dec_reg_write;
			ex_mem_read  <= accept && dec_mem_read;
			ex_mem_write <= accept && dec_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op  <= dec_alu_op;
		ex_src_a   <= dec_src_a;
		ex_use_imm <= dec_use_imm;
		ex_a       <= rs1_data;
		ex_b       <= rs2_data;
		ex_imm     <= dec_imm;
		ex_pc      <= in_pc;
		ex_rd      <= rd;
	end

endmodule

// File: source/mem_writeback.sv
//--------------------------------------------------------------------------
// result stage: word data memory for lw/sw, result select and the
// writeback register that also feeds the register file
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module mem_writeback (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              mw_valid,
	input  logic [rv_isa_pkg::xlen-1:0]       mw_result,
	input  logic [rv_isa_pkg::xlen-1:0]       mw_store_data,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] mw_rd,
	input  logic                              mw_reg_write,
	input  logic                              mw_mem_read,
	input  logic                              mw_mem_write,
	output logic                              wb_valid,
	output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
	output logic [rv_isa_pkg::xlen-1:0]       wb_data
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic [xlen-1:0]        dmem [dmem_words];
	logic [dmem_addr_w-1:0] dmem_idx;
	logic [xlen-1:0]        load_data;
	logic [xlen-1:0]        result;

	// byte address to word index, upper bits wrap
	assign dmem_idx  = mw_result[dmem_addr_w+1:2];
	assign load_data = dmem[dmem_idx];
	assign result    = mw_mem_read ? load_data : mw_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dmem_words; i++) begin
				dmem[i] <= '0;
			end
		end else if (mw_valid && mw_mem_write) begin
			dmem[dmem_idx] <= mw_store_data;
		end
	end

	// x0 writes never reach the writeback port
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= mw_valid && mw_reg_write && (mw_rd != '0);
		end
	end

	always_ff @(posedge clk) begin
		wb_rd   <= mw_rd;
		wb_data <= result;
	end

endmodule

// File: source/reg_file.sv
//--------------------------------------------------------------------------
// integer register file, 32 x 32 bit
// two combinational read ports, one write port, x0 reads as zero
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module reg_file (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr,
	output logic [rv_isa_pkg::xlen-1:0]       rs1_data,
	output logic [rv_isa_pkg::xlen-1:0]       rs2_data,
	input  logic                              rf_we,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rf_waddr,
	input  logic [rv_isa_pkg::xlen-1:0]       rf_wdata
);
	import rv_isa_pkg::*;

	logic [xlen-1:0] regs [32];

	// x0 is never written, but reads force zero anyway
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rf_we && (rf_waddr != '0)) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

endmodule

// File: source/rv_core.sv
//--------------------------------------------------------------------------
// rv32i core top: decode, execute and result stages around the register file
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_core (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              in_valid,
	output logic                              in_ready,
	input  logic [rv_isa_pkg::xlen-1:0]       in_instr,
	input  logic [rv_isa_pkg::xlen-1:0]       in_pc,
	output logic                              wb_valid,
	output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
	output logic [rv_isa_pkg::xlen-1:0]       wb_data
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	// register file read side
	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;

	// decode to execute
	logic                  ex_valid;
	alu_op_t               ex_alu_op;
	src_a_t                ex_src_a;
	logic                  ex_use_imm;
	logic [xlen-1:0]       ex_a;
	logic [xlen-1:0]       ex_b;
	logic [xlen-1:0]       ex_imm;
	logic [xlen-1:0]       ex_pc;
	logic [reg_addr_w-1:0] ex_rd;
	logic                  ex_reg_write;
	logic                  ex_mem_read;
	logic                  ex_mem_write;

	// execute to result
	logic                  mw_valid;
	logic [xlen-1:0]       mw_result;
	logic [xlen-1:0]       mw_store_data;
	logic [reg_addr_w-1:0] mw_rd;
	logic                  mw_reg_write;
	logic                  mw_mem_read;
	logic                  mw_mem_write;

	instr_decode instr_decode_i (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_instr     (in_instr),
		.in_pc        (in_pc),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.mw_rd        (mw_rd),
		.mw_reg_write (mw_reg_write),
		.wb_rd        (wb_rd),
		.wb_valid     (wb_valid),
		.ex_valid     (ex_valid),
		.ex_alu_op    (ex_alu_op),
		.ex_src_a     (ex_src_a),
		.ex_use_imm   (ex_use_imm),
		.ex_a         (ex_a),
		.ex_b         (ex_b),
		.ex_imm       (ex_imm),
		.ex_pc        (ex_pc),
		.ex_rd        (ex_rd),
		.ex_reg_write (ex_reg_write),
		.ex_mem_read  (ex_mem_read),
		.ex_mem_write (ex_mem_write)
	);

	alu_execute alu_execute_i (
		.clk           (clk),
		.rst           (rst),
		.ex_valid      (ex_valid),
		.ex_alu_op     (ex_alu_op),
		.ex_src_a      (ex_src_a),
		.ex_use_imm    (ex_use_imm),
		.ex_a          (ex_a),
		.ex_b          (ex_b),
		.ex_imm        (ex_imm),
		.ex_pc         (ex_pc),
		.ex_rd         (ex_rd),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.mw_valid      (mw_valid),
		.mw_result     (mw_result),
		.mw_store_data (mw_store_data),
		.mw_rd         (mw_rd),
		.mw_reg_write  (mw_reg_write),
		.mw_mem_read   (mw_mem_read),
		.mw_mem_write  (mw_mem_write)
	);

	mem_writeback mem_writeback_i (
		.clk           (clk),
		.rst           (rst),
		.mw_valid      (mw_valid),
		.mw_result     (mw_result),
		.mw_store_data (mw_store_data),
		.mw_rd         (mw_rd),
		.mw_reg_write  (mw_reg_write),
		.mw_mem_read   (mw_mem_read),
		.mw_mem_write  (mw_mem_write),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data)
	);

	// writeback register drives the register file write port directly
	reg_file reg_file_i (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.rf_we    (wb_valid),
		.rf_waddr (wb_rd),
		.rf_wdata (wb_data)
	);

endmodule

// File: source/rv_isa_pkg.sv
//--------------------------------------------------------------------------
// rv32i isa encodings
// opcode values, funct3 codes and the basic field widths
//--------------------------------------------------------------------------

package rv_isa_pkg;

	// data path width
	localparam int xlen = 32;

	// register index width, 32 architectural registers
	localparam int reg_addr_w = 5;

	// major opcodes in instr[6:0]
	// branches and jumps have no entry, they decode as unknown
	typedef enum logic [6:0] {
		op_reg   = 7'b0110011,
		op_imm   = 7'b0010011,
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_load  = 7'b0000011,
		op_store = 7'b0100011
	} opcode_t;

	// alu funct3 codes, shared by op_reg and op_imm
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	// srl or sra, told apart by instr[30]
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// lw / sw width code, the only access size supported
	localparam logic [2:0] f3_word = 3'b010;

endpackage

// File: source/rv_pipe_pkg.sv
//--------------------------------------------------------------------------
// pipeline control definitions
// alu operations, operand a sources and data memory sizing
//--------------------------------------------------------------------------

package rv_pipe_pkg;

	// operations the execute stage knows
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	// where operand a comes from
	typedef enum logic [1:0] {
		src_rs1,
		src_pc,
		src_zero
	} src_a_t;

	// data memory, word addressed
	localparam int dmem_words  = 64;
	localparam int dmem_addr_w = $clog2(dmem_words);

endpackage
